/* filelist.f */
hdl/periph_pkg.sv
hdl/bus_reg_bridge.sv
hdl/periph_decode.sv
hdl/gpio_regs.sv
hdl/event_timer.sv
hdl/intr_ctrl.sv
hdl/periph_subsystem.sv
dv/periph_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= periph_subsystem_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(BUILD_DIR)

/* dv/periph_subsystem_tb.sv */
// Directed testbench for the peripheral subsystem
// Covers bus timing, decode errors, GPIO and timer interrupts and claims

module periph_subsystem_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_GPIO       = 8;
  localparam int NUM_EXT        = 4;
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int TIMER_ID       = 1 + NUM_GPIO;
  localparam int EXT_BASE       = TIMER_ID + 1;

  logic                clk_i;
  logic                reset_i;
  logic                bus_req_i;
  logic                bus_we_i;
  logic [31:0]         bus_addr_i;
  logic [31:0]         bus_wdata_i;
  logic                bus_gnt_o;
  logic                bus_rvalid_o;
  logic [31:0]         bus_rdata_o;
  logic [NUM_GPIO-1:0] gpio_i;
  logic [NUM_GPIO-1:0] gpio_o;
  logic [NUM_GPIO-1:0] gpio_oe_o;
  logic [NUM_EXT-1:0]  ext_intr_i;
  logic                timer_intr_o;
  logic                irq_o;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [31:0] lcg_state = 32'd33445;

  periph_subsystem #(
      .NUM_GPIO(NUM_GPIO),
      .NUM_EXT (NUM_EXT)
  ) periph_subsystem_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .bus_req_i   (bus_req_i),
      .bus_we_i    (bus_we_i),
      .bus_addr_i  (bus_addr_i),
      .bus_wdata_i (bus_wdata_i),
      .bus_gnt_o   (bus_gnt_o),
      .bus_rvalid_o(bus_rvalid_o),
      .bus_rdata_o (bus_rdata_o),
      .gpio_i      (gpio_i),
      .gpio_o      (gpio_o),
      .gpio_oe_o   (gpio_oe_o),
      .ext_intr_i  (ext_intr_i),
      .timer_intr_o(timer_intr_o),
      .irq_o       (irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run stopped by timeout after %0d cycles", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] addr_in_region(input logic [15:0] region,
                                                 input logic [3:0] sel, input logic [9:0] word);
    periph_pkg::periph_addr_u a;
    a.fields.region     = region;
    a.fields.periph_sel = sel;
    a.fields.reg_word   = word;
    a.fields.byte_off   = 2'b00;
    return a.raw;
  endfunction

  function automatic logic [31:0] addr_of(input logic [3:0] sel, input logic [9:0] word);
    return addr_in_region(periph_pkg::PERIPH_REGION, sel, word);
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_pins(input string name, input logic [NUM_GPIO-1:0] exp,
                            input logic [NUM_GPIO-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    reset_i = 1'b1;
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;
  endtask

  // One request, then wait for the response with a bound
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int waited;
    @(negedge clk_i);
    checks++;
    if (bus_rvalid_o !== 1'b0) begin
      errors++;
      $display("Read-valid stayed high longer than one cycle before address %h", addr);
    end
    check_bit("bus_gnt_o", 1'b0, bus_gnt_o);
    bus_req_i   = 1'b1;
    bus_we_i    = we;
    bus_addr_i  = addr;
    bus_wdata_i = wdata;
    @(negedge clk_i);
    check_bit("bus_gnt_o", 1'b1, bus_gnt_o);
    bus_req_i = 1'b0;
    bus_we_i  = 1'b0;
    waited    = 1;
    while (bus_rvalid_o !== 1'b1 && waited < 8) begin
      @(negedge clk_i);
      waited++;
    end
    rdata = bus_rdata_o;
    checks++;
    if (bus_rvalid_o !== 1'b1) begin
      errors++;
      $display("No read-valid response arrived for address %h", addr);
    end else if (waited != 1) begin
      errors++;
      $display("Response for address %h came %0d cycles after the grant", addr, waited);
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] resp;
    bus_access(1'b1, addr, data, resp);
    check_word("bus_rdata_o on write", 32'h0, resp);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(1'b0, addr, 32'h0, data);
  endtask

  task automatic test_readback();
    logic [31:0] out_w;
    logic [31:0] oe_w;
    logic [31:0] cmp_w;
    logic [31:0] rd;
    apply_reset();
    repeat (4) begin
      out_w = next_rand();
      oe_w  = next_rand();
      cmp_w = next_rand();
      bus_write(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OUT), out_w);
      bus_write(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OE), oe_w);
      bus_write(addr_of(periph_pkg::SEL_TIMER, periph_pkg::TMR_COMPARE), cmp_w);
      bus_read(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OUT), rd);
      check_word("GPIO_OUT", 32'(out_w[NUM_GPIO-1:0]), rd);
      bus_read(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OE), rd);
      check_word("GPIO_OE", 32'(oe_w[NUM_GPIO-1:0]), rd);
      bus_read(addr_of(periph_pkg::SEL_TIMER, periph_pkg::TMR_COMPARE), rd);
      check_word("TMR_COMPARE", cmp_w, rd);
      check_pins("gpio_o", out_w[NUM_GPIO-1:0], gpio_o);
      check_pins("gpio_oe_o", oe_w[NUM_GPIO-1:0], gpio_oe_o);
    end
  endtask

  task automatic test_decode_errors();
    logic [31:0] bad [7];
    logic [31:0] rd;
    apply_reset();
    bus_write(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OUT), 32'h5A);
    bus_write(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OE), 32'hC3);
    bus_write(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_INTR_EN), 32'h0F);
    bus_write(addr_of(periph_pkg::SEL_TIMER, periph_pkg::TMR_COMPARE), 32'h1234);
    bus_write(addr_of(periph_pkg::SEL_INTR, periph_pkg::INTR_ENABLE), 32'h6);
    // Wrong region with valid fields below it
    bad[0] = addr_in_region(16'h3009, periph_pkg::SEL_GPIO, periph_pkg::GPIO_OUT);
    bad[1] = addr_in_region(16'h0000, periph_pkg::SEL_TIMER, periph_pkg::TMR_COMPARE);
    bad[2] = addr_of(4'd3, 10'd0);
    bad[3] = addr_of(4'd15, 10'd1);
    bad[4] = addr_of(periph_pkg::SEL_GPIO, 10'd5);
    bad[5] = addr_of(periph_pkg::SEL_TIMER, 10'd4);
    bad[6] = addr_of(periph_pkg::SEL_INTR, 10'd3);
    foreach (bad[i]) begin
      bus_read(bad[i], rd);
      check_word("bus_rdata_o unmapped", periph_pkg::UNMAPPED_RDATA, rd);
      bus_write(bad[i], next_rand());
    end
    bus_read(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OUT), rd);
    check_word("GPIO_OUT", 32'h5A, rd);
    bus_read(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OE), rd);
    check_word("GPIO_OE", 32'hC3, rd);
    bus_read(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_INTR_EN), rd);
    check_word("GPIO_INTR_EN", 32'h0F, rd);
    bus_read(addr_of(periph_pkg::SEL_TIMER, periph_pkg::TMR_COMPARE), rd);
    check_word("TMR_COMPARE", 32'h1234, rd);
    bus_read(addr_of(periph_pkg::SEL_INTR, periph_pkg::INTR_ENABLE), rd);
    check_word("INTR_ENABLE", 32'h6, rd);
  endtask

  task automatic test_gpio_intr();
    logic [NUM_GPIO-1:0] pins;
    logic [NUM_GPIO-1:0] en;
    logic [NUM_GPIO-1:0] clr;
    logic [31:0]         rd;
    apply_reset();
    // Pin 1 always enabled and pin 0 always disabled, both rising
    rd   = next_rand();
    en   = (rd[NUM_GPIO-1:0] | NUM_GPIO'(2)) & ~NUM_GPIO'(1);
    rd   = next_rand();
    pins = rd[NUM_GPIO-1:0] | NUM_GPIO'(3);
    rd   = next_rand();
    clr  = rd[NUM_GPIO-1:0];
    bus_write(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_INTR_EN), 32'(en));
    gpio_i = pins;
    repeat (3) @(negedge clk_i);
    bus_read(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_IN), rd);
    check_word("GPIO_IN", 32'(pins), rd);
    bus_read(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_INTR_STATUS), rd);
    check_word("GPIO_INTR_STATUS", 32'(pins & en), rd);
    bus_write(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_INTR_STATUS), 32'(clr));
    bus_read(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_INTR_STATUS), rd);
    check_word("GPIO_INTR_STATUS", 32'(pins & en & ~clr), rd);
    bus_write(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_INTR_STATUS), 32'hFFFF_FFFF);
    // Falling edges must not set status
    gpio_i = '0;
    repeat (3) @(negedge clk_i);
    bus_read(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_INTR_STATUS), rd);
    check_word("GPIO_INTR_STATUS", 32'h0, rd);
  endtask

  task automatic test_timer();
    logic [31:0] rd;
    int          cmp;
    int          elapsed;
    apply_reset();
    rd  = next_rand();
    cmp = 4 + int'(rd % 32'd8);
    bus_write(addr_of(periph_pkg::SEL_TIMER, periph_pkg::TMR_COMPARE), 32'(cmp));
    bus_write(addr_of(periph_pkg::SEL_TIMER, periph_pkg::TMR_CTRL), 32'h1);
    elapsed = 0;
    rd      = 32'h0;
    while (rd[0] !== 1'b1 && elapsed < 2 * cmp + 4) begin
      bus_read(addr_of(periph_pkg::SEL_TIMER, periph_pkg::TMR_STATUS), rd);
      elapsed += 2;
    end
    checks++;
    if (rd[0] !== 1'b1) begin
      errors++;
      $display("Timer expired flag was not set within %0d cycles", 2 * cmp + 4);
    end
    check_bit("timer_intr_o", 1'b1, timer_intr_o);
    bus_read(addr_of(periph_pkg::SEL_TIMER, periph_pkg::TMR_COUNT), rd);
    checks++;
    if (rd > 32'(cmp)) begin
      errors++;
      $display("[FAIL] TMR_COUNT above compare %h got %h", 32'(cmp), rd);
    end
    bus_write(addr_of(periph_pkg::SEL_TIMER, periph_pkg::TMR_CTRL), 32'h0);
    bus_write(addr_of(periph_pkg::SEL_TIMER, periph_pkg::TMR_STATUS), 32'h1);
    check_bit("timer_intr_o", 1'b0, timer_intr_o);
    bus_read(addr_of(periph_pkg::SEL_TIMER, periph_pkg::TMR_STATUS), rd);
    check_word("TMR_STATUS", 32'h0, rd);
  endtask

  task automatic test_claim();
    logic [31:0] en_mask;
    logic [31:0] exp_pend;
    logic [31:0] rd;
    apply_reset();
    // GPIO pin 1 is id 2, plus external lines 0 and 2
    en_mask               = 32'h0;
    en_mask[2]            = 1'b1;
    en_mask[EXT_BASE]     = 1'b1;
    en_mask[EXT_BASE + 2] = 1'b1;
    bus_write(addr_of(periph_pkg::SEL_GPIO, periph_pkg::GPIO_INTR_EN), 32'h2);
    bus_write(addr_of(periph_pkg::SEL_INTR, periph_pkg::INTR_ENABLE), en_mask);
    ext_intr_i = 4'b1000;
    @(negedge clk_i);
    ext_intr_i = '0;
    repeat (2) @(negedge clk_i);
    check_bit("irq_o", 1'b0, irq_o);
    exp_pend               = 32'h0;
    exp_pend[EXT_BASE + 3] = 1'b1;
    bus_read(addr_of(periph_pkg::SEL_INTR, periph_pkg::INTR_PENDING), rd);
    check_word("INTR_PENDING", exp_pend, rd);
    ext_intr_i = 4'b0101;
    gpio_i     = NUM_GPIO'(2);
    @(negedge clk_i);
    ext_intr_i = '0;
    gpio_i     = '0;
    repeat (4) @(negedge clk_i);
    check_bit("irq_o", 1'b1, irq_o);
    exp_pend = exp_pend | en_mask;
    for (int id = 1; id < 32; id++) begin
      if (exp_pend[id] && en_mask[id]) begin
        bus_read(addr_of(periph_pkg::SEL_INTR, periph_pkg::INTR_CLAIM), rd);
        check_word("INTR_CLAIM", 32'(id), rd);
      end
    end
    bus_read(addr_of(periph_pkg::SEL_INTR, periph_pkg::INTR_CLAIM), rd);
    check_word("INTR_CLAIM", 32'h0, rd);
    check_bit("irq_o", 1'b0, irq_o);
    bus_read(addr_of(periph_pkg::SEL_INTR, periph_pkg::INTR_PENDING), rd);
    check_word("INTR_PENDING", exp_pend & ~en_mask, rd);
  endtask

  initial begin
    reset_i     = 1'b1;
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_addr_i  = 32'h0;
    bus_wdata_i = 32'h0;
    gpio_i      = '0;
    ext_intr_i  = '0;
    test_readback();
    test_decode_errors();
    test_gpio_intr();
    test_timer();
    test_claim();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : periph_subsystem_tb

/* hdl/periph_subsystem.sv */
// Peripheral subsystem top level
// Bus bridge, address decoder, GPIO, event timer and interrupt controller

module periph_subsystem #(
    parameter int NUM_GPIO = 8,
    parameter int NUM_EXT  = 4
) (
    input  logic                clk_i,
    input  logic                reset_i,

    input  logic                bus_req_i,
    input  logic                bus_we_i,
    input  logic [31:0]         bus_addr_i,
    input  logic [31:0]         bus_wdata_i,
    output logic                bus_gnt_o,
    output logic                bus_rvalid_o,
    output logic [31:0]         bus_rdata_o,

    input  logic [NUM_GPIO-1:0] gpio_i,
    output logic [NUM_GPIO-1:0] gpio_o,
    output logic [NUM_GPIO-1:0] gpio_oe_o,

    input  logic [NUM_EXT-1:0]  ext_intr_i,
    output logic                timer_intr_o,
    output logic                irq_o
);

  logic                     reg_valid;
  logic                     reg_write;
  periph_pkg::periph_addr_u reg_addr;
  logic [31:0]              reg_wdata;
  logic [31:0]              reg_rdata;

  logic                     gpio_sel;
  logic                     timer_sel;
  logic                     intr_sel;
  logic                     wr;
  logic [9:0]               word;
  logic [31:0]              wdata;
  logic [31:0]              gpio_rdata;
  logic [31:0]              timer_rdata;
  logic [31:0]              intr_rdata;
  logic [NUM_GPIO-1:0]      gpio_intr;
  logic                     intr_rd;

  // Claim reads have a side effect, so the controller needs a read strobe
  assign intr_rd = intr_sel && !wr;

  bus_reg_bridge bus_reg_bridge_inst (
      .clk_i,
      .reset_i,
      .bus_req_i,
      .bus_we_i,
      .bus_addr_i,
      .bus_wdata_i,
      .bus_gnt_o,
      .bus_rvalid_o,
      .bus_rdata_o,
      .reg_valid_o(reg_valid),
      .reg_write_o(reg_write),
      .reg_addr_o (reg_addr),
      .reg_wdata_o(reg_wdata),
      .reg_rdata_i(reg_rdata)
  );

  periph_decode periph_decode_inst (
      .reg_valid_i  (reg_valid),
      .reg_write_i  (reg_write),
      .reg_addr_i   (reg_addr),
      .reg_wdata_i  (reg_wdata),
      .gpio_sel_o   (gpio_sel),
      .timer_sel_o  (timer_sel),
      .intr_sel_o   (intr_sel),
      .wr_o         (wr),
      .word_o       (word),
      .wdata_o      (wdata),
      .gpio_rdata_i (gpio_rdata),
      .timer_rdata_i(timer_rdata),
      .intr_rdata_i (intr_rdata),
      .reg_rdata_o  (reg_rdata)
  );

  gpio_regs #(
      .NUM_GPIO(NUM_GPIO)
  ) gpio_regs_inst (
      .clk_i,
      .reset_i,
      .sel_i    (gpio_sel),
      .wr_i     (wr),
      .word_i   (word),
      .wdata_i  (wdata),
      .rdata_o  (gpio_rdata),
      .gpio_i,
      .gpio_o,
      .gpio_oe_o,
      .intr_o   (gpio_intr)
  );

  event_timer event_timer_inst (
      .clk_i,
      .reset_i,
      .sel_i  (timer_sel),
      .wr_i   (wr),
      .word_i (word),
      .wdata_i(wdata),
      .rdata_o(timer_rdata),
      .intr_o (timer_intr_o)
  );

  intr_ctrl #(
      .NUM_GPIO(NUM_GPIO),
      .NUM_EXT (NUM_EXT)
  ) intr_ctrl_inst (
      .clk_i,
      .reset_i,
      .sel_i       (intr_sel),
      .rd_i        (intr_rd),
      .wr_i        (wr),
      .word_i      (word),
      .wdata_i     (wdata),
      .rdata_o     (intr_rdata),
      .gpio_intr_i (gpio_intr),
      .timer_intr_i(timer_intr_o),
      .ext_intr_i,
      .irq_o
  );

endmodule : periph_subsystem

/* hdl/intr_ctrl.sv */
// Interrupt controller with edge-triggered pending bits and per-source enables
// Reading the claim register returns and clears the lowest active source

module intr_ctrl #(
    parameter int NUM_GPIO = 8,
    parameter int NUM_EXT  = 4
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                sel_i,
    input  logic                rd_i,
    input  logic                wr_i,
    input  logic [9:0]          word_i,
    input  logic [31:0]         wdata_i,
    output logic [31:0]         rdata_o,
    input  logic [NUM_GPIO-1:0] gpio_intr_i,
    input  logic                timer_intr_i,
    input  logic [NUM_EXT-1:0]  ext_intr_i,
    output logic                irq_o
);

  // Id 0 means no interrupt; at most 32 sources fit one register
  localparam int NUM_SRC = 1 + NUM_GPIO + 1 + NUM_EXT;
  localparam int ID_W    = $clog2(NUM_SRC);

  logic [NUM_SRC-1:0] src;
  logic [NUM_SRC-1:0] src_q;
  logic [NUM_SRC-1:0] pending_q;
  logic [NUM_SRC-1:0] enable_q;
  logic [NUM_SRC-1:0] active;
  logic [NUM_SRC-1:0] claim_mask;
  logic [ID_W-1:0]    claim_id;
  logic               claim_rd;

  assign src      = {ext_intr_i, timer_intr_i, gpio_intr_i, 1'b0};
  assign active   = pending_q & enable_q;
  assign claim_rd = rd_i && (word_i == periph_pkg::INTR_CLAIM);

  // Lowest numbered active source
  always_comb begin
    claim_id   = '0;
    claim_mask = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) begin
        claim_id   = ID_W'(i);
        claim_mask = '0;
        claim_mask[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q     <= '0;
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      src_q     <= src;
      pending_q <= (pending_q & ~(claim_rd ? claim_mask : '0)) | (src & ~src_q);
      if (sel_i && wr_i && word_i == periph_pkg::INTR_ENABLE) begin
        enable_q <= wdata_i[NUM_SRC-1:0];
      end
    end
  end

  always_comb begin
    case (word_i)
      periph_pkg::INTR_ENABLE:  rdata_o = 32'(enable_q);
      periph_pkg::INTR_PENDING: rdata_o = 32'(pending_q);
      periph_pkg::INTR_CLAIM:   rdata_o = 32'(claim_id);
      default:                  rdata_o = periph_pkg::UNMAPPED_RDATA;
    endcase
  end

  assign irq_o = |active;

endmodule : intr_ctrl

/* hdl/event_timer.sv */
// Event timer
// Counts up to the compare value, wraps and raises a sticky expired flag

module event_timer (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        sel_i,
    input  logic        wr_i,
    input  logic [9:0]  word_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o,
    output logic        intr_o
);

  logic        enable_q;
  logic [31:0] count_q;
  logic [31:0] compare_q;
  logic        expired_q;
  logic        wr_en;
  logic        match;

  assign wr_en = sel_i && wr_i;
  assign match = enable_q && (count_q == compare_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q  <= 1'b0;
      count_q   <= '0;
      compare_q <= '0;
      expired_q <= 1'b0;
    end else begin
      if (wr_en && word_i == periph_pkg::TMR_COUNT) begin
        count_q <= wdata_i;
      end else if (match) begin
        count_q <= '0;
      end else if (enable_q) begin
        count_q <= count_q + 32'd1;
      end

      if (match) begin
        expired_q <= 1'b1;
      end else if (wr_en && word_i == periph_pkg::TMR_STATUS && wdata_i[0]) begin
        expired_q <= 1'b0;
      end

      if (wr_en && word_i == periph_pkg::TMR_CTRL)    enable_q  <= wdata_i[0];
      if (wr_en && word_i == periph_pkg::TMR_COMPARE) compare_q <= wdata_i;
    end
  end

  always_comb begin
    case (word_i)
      periph_pkg::TMR_CTRL:    rdata_o = {31'h0, enable_q};
      periph_pkg::TMR_COUNT:   rdata_o = count_q;
      periph_pkg::TMR_COMPARE: rdata_o = compare_q;
      periph_pkg::TMR_STATUS:  rdata_o = {31'h0, expired_q};
      default:                 rdata_o = periph_pkg::UNMAPPED_RDATA;
    endcase
  end

  assign intr_o = expired_q;

endmodule : event_timer

/* hdl/gpio_regs.sv */
// GPIO block with output, output enable and synchronized inputs
// Enabled pins latch a status bit on a rising edge

module gpio_regs #(
    parameter int NUM_GPIO = 8
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                sel_i,
    input  logic                wr_i,
    input  logic [9:0]          word_i,
    input  logic [31:0]         wdata_i,
    output logic [31:0]         rdata_o,
    input  logic [NUM_GPIO-1:0] gpio_i,
    output logic [NUM_GPIO-1:0] gpio_o,
    output logic [NUM_GPIO-1:0] gpio_oe_o,
    output logic [NUM_GPIO-1:0] intr_o
);

  logic [NUM_GPIO-1:0] out_q;
  logic [NUM_GPIO-1:0] oe_q;
  logic [NUM_GPIO-1:0] in_meta_q;
  logic [NUM_GPIO-1:0] in_sync_q;
  logic [NUM_GPIO-1:0] intr_en_q;
  logic [NUM_GPIO-1:0] status_q;
  logic [NUM_GPIO-1:0] rise_set;
  logic [NUM_GPIO-1:0] status_clr;
  logic                wr_en;

  assign wr_en = sel_i && wr_i;

  // Edge seen between the two synchronizer stages
  assign rise_set   = in_meta_q & ~in_sync_q & intr_en_q;
  assign status_clr = (wr_en && word_i == periph_pkg::GPIO_INTR_STATUS) ?
                      wdata_i[NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      in_meta_q <= '0;
      in_sync_q <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
      // A new edge wins over a clear in the same cycle
      status_q  <= (status_q & ~status_clr) | rise_set;
      if (wr_en && word_i == periph_pkg::GPIO_OUT)     out_q     <= wdata_i[NUM_GPIO-1:0];
      if (wr_en && word_i == periph_pkg::GPIO_OE)      oe_q      <= wdata_i[NUM_GPIO-1:0];
      if (wr_en && word_i == periph_pkg::GPIO_INTR_EN) intr_en_q <= wdata_i[NUM_GPIO-1:0];
    end
  end

  always_comb begin
    case (word_i)
      periph_pkg::GPIO_OUT:         rdata_o = 32'(out_q);
      periph_pkg::GPIO_OE:          rdata_o = 32'(oe_q);
      periph_pkg::GPIO_IN:          rdata_o = 32'(in_sync_q);
      periph_pkg::GPIO_INTR_EN:     rdata_o = 32'(intr_en_q);
      periph_pkg::GPIO_INTR_STATUS: rdata_o = 32'(status_q);
      default:                      rdata_o = periph_pkg::UNMAPPED_RDATA;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign intr_o    = status_q;

endmodule : gpio_regs

/* hdl/periph_decode.sv */
// Register address decoder
// Routes a register strobe to one peripheral and muxes its read data back

module periph_decode (
    input  logic                      reg_valid_i,
    input  logic                      reg_write_i,
    input  periph_pkg::periph_addr_u  reg_addr_i,
    input  logic [31:0]               reg_wdata_i,

    output logic                      gpio_sel_o,
    output logic                      timer_sel_o,
    output logic                      intr_sel_o,

    output logic                      wr_o,
    output logic [9:0]                word_o,
    output logic [31:0]               wdata_o,

    input  logic [31:0]               gpio_rdata_i,
    input  logic [31:0]               timer_rdata_i,
    input  logic [31:0]               intr_rdata_i,
    output logic [31:0]               reg_rdata_o
);

  logic       region_hit;
  logic [3:0] sel_idx;

  assign region_hit = (reg_addr_i.fields.region == periph_pkg::PERIPH_REGION);
  assign sel_idx    = reg_addr_i.fields.periph_sel;

  assign gpio_sel_o  = reg_valid_i && region_hit && (sel_idx == periph_pkg::SEL_GPIO);
  assign timer_sel_o = reg_valid_i && region_hit && (sel_idx == periph_pkg::SEL_TIMER);
  assign intr_sel_o  = reg_valid_i && region_hit && (sel_idx == periph_pkg::SEL_INTR);

  assign wr_o    = reg_write_i;
  assign word_o  = reg_addr_i.fields.reg_word;
  assign wdata_o = reg_wdata_i;

  always_comb begin
    if (gpio_sel_o) begin
      reg_rdata_o = gpio_rdata_i;
    end else if (timer_sel_o) begin
      reg_rdata_o = timer_rdata_i;
    end else if (intr_sel_o) begin
      reg_rdata_o = intr_rdata_i;
    end else begin
      reg_rdata_o = periph_pkg::UNMAPPED_RDATA;
    end
  end

endmodule : periph_decode

/* hdl/bus_reg_bridge.sv */
// Bus slave front end
// Grants each request at once and answers one cycle later

module bus_reg_bridge (
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  logic                      bus_req_i,
    input  logic                      bus_we_i,
    input  logic [31:0]               bus_addr_i,
    input  logic [31:0]               bus_wdata_i,
    output logic                      bus_gnt_o,
    output logic                      bus_rvalid_o,
    output logic [31:0]               bus_rdata_o,

    output logic                      reg_valid_o,
    output logic                      reg_write_o,
    output periph_pkg::periph_addr_u  reg_addr_o,
    output logic [31:0]               reg_wdata_o,
    input  logic [31:0]               reg_rdata_i
);

  logic        rvalid_q;
  logic [31:0] rdata_q;

  // No back-pressure, so grant and strobe track the request
  assign bus_gnt_o       = bus_req_i;
  assign reg_valid_o     = bus_req_i;
  assign reg_write_o     = bus_we_i;
  assign reg_addr_o.raw  = bus_addr_i;
  assign reg_wdata_o     = bus_wdata_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i;
    end
  end

  // Write responses carry zero data
  always_ff @(posedge clk_i) begin
    if (bus_req_i) begin
      rdata_q <= bus_we_i ? 32'h0 : reg_rdata_i;
    end
  end

  assign bus_rvalid_o = rvalid_q;
  assign bus_rdata_o  = rdata_q;

endmodule : bus_reg_bridge

/* hdl/periph_pkg.sv */
// Peripheral subsystem shared definitions
// Address layout, peripheral indices and register word map

package periph_pkg;

  // One bus address, seen raw or split into decode fields
  typedef struct packed {
    logic [15:0] region;
    logic [3:0]  periph_sel;
    logic [9:0]  reg_word;
    logic [1:0]  byte_off;
  } periph_addr_fields_t;

  typedef union packed {
    logic [31:0]         raw;
    periph_addr_fields_t fields;
  } periph_addr_u;

  localparam logic [15:0] PERIPH_REGION = 16'h3008;

  localparam logic [3:0] SEL_INTR  = 4'd0;
  localparam logic [3:0] SEL_GPIO  = 4'd1;
  localparam logic [3:0] SEL_TIMER = 4'd2;

  localparam logic [31:0] UNMAPPED_RDATA = 32'hDEADBEEF;

  // GPIO register words
  localparam logic [9:0] GPIO_OUT         = 10'd0;
  localparam logic [9:0] GPIO_OE          = 10'd1;
  localparam logic [9:0] GPIO_IN          = 10'd2;
  localparam logic [9:0] GPIO_INTR_EN     = 10'd3;
  localparam logic [9:0] GPIO_INTR_STATUS = 10'd4;

  // Timer register words
  localparam logic [9:0] TMR_CTRL    = 10'd0;
  localparam logic [9:0] TMR_COUNT   = 10'd1;
  localparam logic [9:0] TMR_COMPARE = 10'd2;
  localparam logic [9:0] TMR_STATUS  = 10'd3;

  // Interrupt controller register words
  localparam logic [9:0] INTR_ENABLE  = 10'd0;
  localparam logic [9:0] INTR_PENDING = 10'd1;
  localparam logic [9:0] INTR_CLAIM   = 10'd2;

endpackage : periph_pkg
